// File: list.f
source/stream_pkg.sv
source/stream_addressgen.sv
source/stream_source.sv
source/tcdm_banks.sv
source/stream_source_top.sv
test/stream_source_chk.sv
test/tb_stream_source.sv

// File: test/tb_stream_source.sv
// ################################################
// testbench for the stream source top level
// fills memory over the host port, runs strided
// transfers and checks each beat against a model
// ################################################

`timescale 1ns/100ps
`default_nettype none

module tb_stream_source;

  localparam int unsigned NB_PORTS    = 2;
  localparam int unsigned MEM_WORDS   = 256;
  localparam int unsigned DATA_W      = NB_PORTS * stream_pkg::WORD_W;
  localparam int unsigned TOTAL_BEATS = 16 + 24 + 32 + 32 + 40 + 12;
  localparam int unsigned WDOG_CYCLES = TOTAL_BEATS * 20 + MEM_WORDS + 200;

  logic                          clk;
  logic                          rst_n;
  logic                          clear;
  stream_pkg::ctrl_source_t      ctrl;
  stream_pkg::flags_source_t     flags;
  logic                          stream_valid;
  logic                          stream_ready;
  logic [DATA_W-1:0]             stream_data;
  logic                          wr_en;
  logic [stream_pkg::ADDR_W-1:0] wr_addr;
  logic [stream_pkg::WORD_W-1:0] wr_data;

  logic [stream_pkg::WORD_W-1:0] image [MEM_WORDS]; // mirror of the banks
  stream_pkg::ctrl_source_t      cur_ctrl;          // transfer being checked
  int unsigned                   beat_idx;
  int unsigned                   done_cnt;
  int unsigned                   done_base;
  int unsigned                   err_cnt;
  int unsigned                   beats_checked;
  logic                          rand_ready;
  logic                          host_busy;
  int unsigned                   seed;

  stream_source_top #(
    .NB_PORTS  ( NB_PORTS  ),
    .MEM_WORDS ( MEM_WORDS )
  ) DUT (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .clear_i        ( clear        ),
    .ctrl_i         ( ctrl         ),
    .flags_o        ( flags        ),
    .stream_valid_o ( stream_valid ),
    .stream_ready_i ( stream_ready ),
    .stream_data_o  ( stream_data  ),
    .wr_en_i        ( wr_en        ),
    .wr_addr_i      ( wr_addr      ),
    .wr_data_i      ( wr_data      )
  );

  always #4 clk = ~clk;

  function automatic logic [stream_pkg::WORD_W-1:0] fill_word(logic [15:0] idx);
    return {idx ^ 16'hc3a5, idx * 16'd37 + 16'h0101};
  endfunction

  // expected beat k from the image by line, column and port
  function automatic logic [DATA_W-1:0] ref_beat(stream_pkg::ctrl_source_t c, int unsigned k);
    int unsigned row;
    int unsigned col;
    int unsigned addr;
    logic [DATA_W-1:0] beat;
    row  = k / c.line_length;
    col  = k % c.line_length;
    addr = c.base_addr + row * c.line_stride + col * 4 * NB_PORTS;
    for (int i = 0; i < NB_PORTS; i++) begin
      beat[i*stream_pkg::WORD_W +: stream_pkg::WORD_W] = image[((addr + 4 * i) / 4) % MEM_WORDS];
    end
    return beat;
  endfunction

  task automatic check_value(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic drive_write(logic [stream_pkg::ADDR_W-1:0] addr,
                             logic [stream_pkg::WORD_W-1:0] data);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    image[(addr / 4) % MEM_WORDS] = data;
  endtask

  task automatic start_transfer(logic [15:0] base, logic [15:0] size, logic [15:0] len,
                                logic [15:0] stride);
    stream_pkg::ctrl_source_t c;
    @(negedge clk);
    c = '{req_start: 1'b0, base_addr: base, trans_size: size, line_length: len,
          line_stride: stride};
    cur_ctrl  = c;
    beat_idx  = 0;
    done_base = done_cnt;
    check_value("ready_start", flags.ready_start, 1'b1);
    c.req_start = 1'b1;
    @(posedge clk);
    ctrl <= c;
    @(posedge clk);
    ctrl.req_start <= 1'b0;
    @(negedge clk);
    check_value("ready_start", flags.ready_start, 1'b0);
    check_value("in_progress", flags.in_progress, 1'b1);
  endtask

  task automatic run_transfer(logic [15:0] base, logic [15:0] size, logic [15:0] len,
                              logic [15:0] stride);
    start_transfer(base, size, len, stride);
    do @(negedge clk); while (done_cnt == done_base);
    check_value("beat_count", beat_idx, size);
    check_value("ready_start", flags.ready_start, 1'b1);
    check_value("in_progress", flags.in_progress, 1'b0);
    repeat (3) @(negedge clk);
    check_value("done_count", done_cnt - done_base, 1);
  endtask

  always @(posedge clk) begin
    stream_ready <= rand_ready ? ($urandom % 4 != 0) : 1'b1;
  end

  always @(posedge clk) begin
    if (stream_valid && stream_ready) begin
      if (beat_idx >= cur_ctrl.trans_size) begin
        err_cnt++;
        $display("error at %0t: beat accepted after the transfer was complete", $time);
      end else begin
        check_value("stream_data", stream_data, ref_beat(cur_ctrl, beat_idx));
        beats_checked++;
      end
      beat_idx++;
    end
    if (flags.done) begin
      done_cnt++;
      if (beat_idx != cur_ctrl.trans_size) begin
        err_cnt++;
        $display("error at %0t: done pulse before the final beat was accepted", $time);
      end
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("error: no finish within %0d cycles, a transfer hung", WDOG_CYCLES);
    $display("errors: %0d, beats checked: %0d", err_cnt + 1, beats_checked);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int unsigned seen;
    seed = 32'h5255_9eb4;
    void'($urandom(seed));
    clk  = 1'b0;
    rst_n = 1'b0;
    clear = 1'b0;
    ctrl  = '0;
    stream_ready = 1'b1;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    cur_ctrl   = '0;
    rand_ready = 1'b0;
    host_busy  = 1'b0;
    beat_idx = 0;
    done_cnt = 0;
    done_base = 0;
    err_cnt  = 0;
    beats_checked = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("ready_start", flags.ready_start, 1'b1);
    check_value("in_progress", flags.in_progress, 1'b0);
    check_value("done", flags.done, 1'b0);
    check_value("stream_valid", stream_valid, 1'b0);

    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      drive_write(16'(i * 4), fill_word(16'(i)));
    end
    @(posedge clk);
    wr_en <= 1'b0;

    run_transfer(16'h0000, 16'd16, 16'd16, 16'd0);
    run_transfer(16'h0080, 16'd24, 16'd6, 16'd64); // lines spaced past their length
    rand_ready = 1'b1;
    run_transfer(16'h0040, 16'd32, 16'd8, 16'd80);
    rand_ready = 1'b0;

    // host writes above the block steal bank grants
    host_busy = 1'b1;
    fork
      begin
        run_transfer(16'h0000, 16'd32, 16'd32, 16'd0);
        host_busy = 1'b0;
      end
      while (host_busy) begin
        @(posedge clk);
        if ($urandom % 3 != 0) begin
          drive_write(16'h0200 + 16'(($urandom % 128) * 4), $urandom);
        end else begin
          wr_en <= 1'b0;
        end
      end
    join
    @(posedge clk);
    wr_en <= 1'b0;

    // abort part way through
    start_transfer(16'h0100, 16'd40, 16'd40, 16'd0);
    do @(negedge clk); while (beat_idx < 5);
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(negedge clk);
    seen = beat_idx;
    check_value("ready_start", flags.ready_start, 1'b1);
    check_value("in_progress", flags.in_progress, 1'b0);
    repeat (10) @(negedge clk);
    check_value("beats_after_clear", beat_idx, seen);
    check_value("done_count", done_cnt, done_base);
    run_transfer(16'h0180, 16'd12, 16'd4, 16'd40);

    $display("errors: %0d, beats checked: %0d", err_cnt, beats_checked);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/stream_source_chk.sv
// ################################################
// stream source protocol checker
// stalled beats hold, reads only while working,
// done stays a single-cycle pulse
// ################################################

`timescale 1ns/100ps
`default_nettype none

module stream_source_chk #(
  parameter int unsigned NB_PORTS = 2
) (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic                                   clear_i,
  input stream_pkg::source_state_e              state_i,
  input stream_pkg::flags_source_t              flags_i,
  input stream_pkg::tcdm_req_t [NB_PORTS-1:0]   req_i,
  input logic                                   valid_i,
  input logic                                   ready_i,
  input logic [NB_PORTS*stream_pkg::WORD_W-1:0] data_i
);

  logic [NB_PORTS-1:0] req_vec;

  for (genvar i = 0; i < NB_PORTS; i++) begin : gen_req
    assign req_vec[i] = req_i[i].req;
  end

  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    valid_i && !ready_i |=> valid_i && $stable(data_i))
  else $error("stream beat dropped or changed while stalled");

  a_req_working: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i != stream_pkg::SRC_WORKING |-> req_vec == '0)
  else $error("memory request raised outside the working state");

  // done is a pulse
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_i.done |=> !flags_i.done)
  else $error("done held high for two cycles");

endmodule

bind stream_source stream_source_chk #(
  .NB_PORTS ( NB_PORTS )
) i_chk (
  .clk_i   ( clk_i          ),
  .rst_ni  ( rst_ni         ),
  .clear_i ( clear_i        ),
  .state_i ( state_q        ),
  .flags_i ( flags_o        ),
  .req_i   ( tcdm_req_o     ),
  .valid_i ( stream_valid_o ),
  .ready_i ( stream_ready_i ),
  .data_i  ( stream_data_o  )
);

`default_nettype wire

// File: source/stream_source_top.sv
// ################################################
// stream source top
// source wired to its banked local memory
// ################################################

`timescale 1ns/100ps
`default_nettype none

module stream_source_top #(
  parameter int unsigned NB_PORTS  = 2,
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  input  stream_pkg::ctrl_source_t               ctrl_i,
  output stream_pkg::flags_source_t              flags_o,
  output logic                                   stream_valid_o,
  input  logic                                   stream_ready_i,
  output logic [NB_PORTS*stream_pkg::WORD_W-1:0] stream_data_o,
  input  logic                                   wr_en_i,
  input  logic [stream_pkg::ADDR_W-1:0]          wr_addr_i,
  input  logic [stream_pkg::WORD_W-1:0]          wr_data_i
);

  stream_pkg::tcdm_req_t [NB_PORTS-1:0] tcdm_req; // one port per bank
  stream_pkg::tcdm_rsp_t [NB_PORTS-1:0] tcdm_rsp;

  stream_source #(
    .NB_PORTS ( NB_PORTS )
  ) i_source (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .ctrl_i         ( ctrl_i         ),
    .flags_o        ( flags_o        ),
    .tcdm_req_o     ( tcdm_req       ),
    .tcdm_rsp_i     ( tcdm_rsp       ),
    .stream_valid_o ( stream_valid_o ),
    .stream_ready_i ( stream_ready_i ),
    .stream_data_o  ( stream_data_o  )
  );

  tcdm_banks #(
    .NB_PORTS  ( NB_PORTS  ),
    .MEM_WORDS ( MEM_WORDS )
  ) i_banks (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .req_i     ( tcdm_req  ),
    .rsp_o     ( tcdm_rsp  ),
    .wr_en_i   ( wr_en_i   ),
    .wr_addr_i ( wr_addr_i ),
    .wr_data_i ( wr_data_i )
  );

endmodule

`default_nettype wire

// File: source/tcdm_banks.sv
// ################################################
// banked local memory
// word-interleaved banks, one read port per bank,
// host writes win the bank, reads return a cycle
// after the grant
// ################################################

`timescale 1ns/100ps
`default_nettype none

module tcdm_banks #(
  parameter int unsigned NB_PORTS  = 2,
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  stream_pkg::tcdm_req_t [NB_PORTS-1:0] req_i,
  output stream_pkg::tcdm_rsp_t [NB_PORTS-1:0] rsp_o,
  input  logic                                 wr_en_i,
  input  logic [stream_pkg::ADDR_W-1:0]        wr_addr_i,
  input  logic [stream_pkg::WORD_W-1:0]        wr_data_i
);

  localparam int unsigned ROWS   = MEM_WORDS / NB_PORTS;
  localparam int unsigned ROW_W  = $clog2(ROWS);
  localparam int unsigned BANK_W = $clog2(NB_PORTS);

  logic [BANK_W-1:0] wr_bank;
  logic [ROW_W-1:0]  wr_row;

  // low word bits pick the bank, the rest the row
  assign wr_bank = wr_addr_i[2 +: BANK_W];
  assign wr_row  = wr_addr_i[2 + BANK_W +: ROW_W];

  for (genvar b = 0; b < NB_PORTS; b++) begin : gen_bank
    localparam logic [BANK_W-1:0] BANK_ID = b;

    logic [stream_pkg::WORD_W-1:0] mem_q [ROWS];
    logic [stream_pkg::WORD_W-1:0] rdata_q;
    logic                          rvalid_q;
    logic [ROW_W-1:0]              rd_row;
    logic                          wr_hit;
    logic                          gnt;

    assign rd_row = req_i[b].add[2 + BANK_W +: ROW_W];
    assign wr_hit = wr_en_i & (wr_bank == BANK_ID);
    assign gnt    = req_i[b].req & ~wr_hit; // host write has priority

    always_ff @(posedge clk_i) begin
      if (wr_hit) begin
        mem_q[wr_row] <= wr_data_i;
      end
      if (gnt) begin
        rdata_q <= mem_q[rd_row];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rvalid_q <= 1'b0;
      end else begin
        rvalid_q <= gnt;
      end
    end

    assign rsp_o[b] = '{gnt: gnt, r_valid: rvalid_q, r_data: rdata_q};
  end

endmodule

`default_nettype wire

// File: source/stream_source.sv
// ################################################
// stream source
// reads beats over parallel memory ports, fences
// lost grants, merges words into a wide stream
// beat and flags completion
// ################################################

`timescale 1ns/100ps
`default_nettype none

module stream_source #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     clear_i,
  input  stream_pkg::ctrl_source_t                 ctrl_i,
  output stream_pkg::flags_source_t                flags_o,
  output stream_pkg::tcdm_req_t [NB_PORTS-1:0]     tcdm_req_o,
  input  stream_pkg::tcdm_rsp_t [NB_PORTS-1:0]     tcdm_rsp_i,
  output logic                                     stream_valid_o,
  input  logic                                     stream_ready_i,
  output logic [NB_PORTS*stream_pkg::WORD_W-1:0]   stream_data_o
);

  stream_pkg::source_state_e     state_q;
  stream_pkg::ctrl_source_t      ag_ctrl;
  logic [stream_pkg::ADDR_W-1:0] gen_addr;
  logic                          ag_busy;
  logic                          ag_enable;
  logic                          issue;
  logic [NB_PORTS-1:0]           granted_q;
  logic [NB_PORTS-1:0]           port_gnt;
  logic                          all_gnt;
  logic [NB_PORTS-1:0]           avail;
  logic                          beat_fire;
  logic [15:0]                   beat_cnt_q;
  logic                          last_beat;
  logic                          done_q;

  // the generator only sees a start taken in idle
  always_comb begin
    ag_ctrl           = ctrl_i;
    ag_ctrl.req_start = ctrl_i.req_start & (state_q == stream_pkg::SRC_IDLE);
  end

  stream_addressgen #(
    .NB_PORTS ( NB_PORTS )
  ) i_addressgen (
    .clk_i         ( clk_i     ),
    .rst_ni        ( rst_ni    ),
    .clear_i       ( clear_i   ),
    .enable_i      ( ag_enable ),
    .ctrl_i        ( ag_ctrl   ),
    .addr_o        ( gen_addr  ),
    .in_progress_o ( ag_busy   )
  );

  // back-pressure: no new reads while ready is low
  assign issue = (state_q == stream_pkg::SRC_WORKING) & stream_ready_i & ag_busy & ~clear_i;

  assign all_gnt   = &port_gnt;
  assign ag_enable = issue & all_gnt;

  for (genvar i = 0; i < NB_PORTS; i++) begin : gen_port
    localparam logic [stream_pkg::ADDR_W-1:0] PORT_OFFS = 4 * i;

    logic                          hold_valid_q;
    logic [stream_pkg::WORD_W-1:0] hold_data_q;

    assign tcdm_req_o[i].req = issue & ~granted_q[i];
    assign tcdm_req_o[i].add = gen_addr + PORT_OFFS;
    assign port_gnt[i] = granted_q[i] | (tcdm_req_o[i].req & tcdm_rsp_i[i].gnt);

    // one-deep hold, bypassed when the word arrives
    assign avail[i] = hold_valid_q | tcdm_rsp_i[i].r_valid;
    assign stream_data_o[i*stream_pkg::WORD_W +: stream_pkg::WORD_W] =
      hold_valid_q ? hold_data_q : tcdm_rsp_i[i].r_data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        hold_valid_q <= 1'b0;
      end else if (clear_i || beat_fire) begin
        hold_valid_q <= 1'b0;
      end else if (tcdm_rsp_i[i].r_valid) begin
        hold_valid_q <= 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (tcdm_rsp_i[i].r_valid && !hold_valid_q) begin
        hold_data_q <= tcdm_rsp_i[i].r_data;
      end
    end
  end

  // granted ports sit out until the whole beat is granted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      granted_q <= '0;
    end else if (clear_i) begin
      granted_q <= '0;
    end else if (issue) begin
      granted_q <= all_gnt ? '0 : port_gnt;
    end
  end

  assign stream_valid_o = (&avail) & ~clear_i;
  assign beat_fire      = stream_valid_o & stream_ready_i;
  assign last_beat      = (beat_cnt_q == ctrl_i.trans_size - 16'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else if (clear_i) begin
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= beat_fire & last_beat;
      if (beat_fire) begin
        beat_cnt_q <= last_beat ? 16'd0 : beat_cnt_q + 16'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= stream_pkg::SRC_IDLE;
    end else if (clear_i) begin
      state_q <= stream_pkg::SRC_IDLE;
    end else begin
      case (state_q)
        stream_pkg::SRC_IDLE: begin
          if (ctrl_i.req_start) begin
            state_q <= stream_pkg::SRC_WORKING;
          end
        end
        stream_pkg::SRC_WORKING: begin
          if (beat_fire && last_beat) begin // final beat taken
            state_q <= stream_pkg::SRC_IDLE;
          end
        end
        default: state_q <= stream_pkg::SRC_IDLE;
      endcase
    end
  end

  assign flags_o = '{
    ready_start: (state_q == stream_pkg::SRC_IDLE),
    done:        done_q,
    in_progress: ag_busy
  };

endmodule

`default_nettype wire

// File: source/stream_addressgen.sv
// ################################################
// stream address generator
// walks a strided two-level block one beat at a
// time and flags when beats are left to issue
// ################################################

`timescale 1ns/100ps
`default_nettype none

module stream_addressgen #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          enable_i,
  input  stream_pkg::ctrl_source_t      ctrl_i,
  output logic [stream_pkg::ADDR_W-1:0] addr_o,
  output logic                          in_progress_o
);

  localparam int unsigned STEP = 4 * NB_PORTS; // bytes per beat

  logic                          busy_q;
  logic [15:0]                   beat_cnt_q;
  logic [15:0]                   col_cnt_q;
  logic [stream_pkg::ADDR_W-1:0] col_off_q;
  logic [stream_pkg::ADDR_W-1:0] line_off_q;
  logic                          last_beat;
  logic                          last_col;

  assign last_beat = (beat_cnt_q == ctrl_i.trans_size - 16'd1);
  assign last_col  = (col_cnt_q == ctrl_i.line_length - 16'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
      col_cnt_q  <= '0;
      col_off_q  <= '0;
      line_off_q <= '0;
    end else if (clear_i) begin
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
      col_cnt_q  <= '0;
      col_off_q  <= '0;
      line_off_q <= '0;
    end else if (ctrl_i.req_start) begin
      busy_q     <= 1'b1;
      beat_cnt_q <= '0;
      col_cnt_q  <= '0;
      col_off_q  <= '0;
      line_off_q <= '0;
    end else if (enable_i && busy_q) begin
      beat_cnt_q <= beat_cnt_q + 16'd1;
      busy_q     <= ~last_beat;
      if (last_col) begin // wrap to next line
        col_cnt_q  <= '0;
        col_off_q  <= '0;
        line_off_q <= line_off_q + ctrl_i.line_stride;
      end else begin
        col_cnt_q <= col_cnt_q + 16'd1;
        col_off_q <= col_off_q + STEP[stream_pkg::ADDR_W-1:0];
      end
    end
  end

  assign addr_o        = ctrl_i.base_addr + line_off_q + col_off_q;
  assign in_progress_o = busy_q;

endmodule

`default_nettype wire

// File: source/stream_pkg.sv
// ################################################
// stream package
// shared types for the memory-to-stream source:
// control and flags, memory port request and
// response, source FSM states
// ################################################

`default_nettype none

package stream_pkg;

  parameter int unsigned ADDR_W = 16;
  parameter int unsigned WORD_W = 32;

  typedef struct packed {
    logic              req_start;
    logic [ADDR_W-1:0] base_addr;   // byte address, beat aligned
    logic [15:0]       trans_size;  // total beats
    logic [15:0]       line_length; // beats per line
    logic [15:0]       line_stride; // bytes between line starts
  } ctrl_source_t;

  typedef struct packed {
    logic ready_start;
    logic done;
    logic in_progress;
  } flags_source_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] add;
  } tcdm_req_t;

  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [WORD_W-1:0] r_data;
  } tcdm_rsp_t;

  typedef enum logic {
    SRC_IDLE,
    SRC_WORKING
  } source_state_e;

endpackage

`default_nettype wire
